//--- Makefile
VERILATOR  = verilator
COMMON     = --timing --assert --timescale 1ns/10ps
LINT_FLAGS = --lint-only $(COMMON)
SIM_FLAGS  = --binary $(COMMON)
TOP        = tb_panel
FILELIST   = list.f
OBJ_DIR    = obj_dir
LOG        = sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "Test OK" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/tb_panel.sv
`timescale 1ns/10ps

module tb_panel;

    localparam int          QDIV        = 2;                       // Clocks per quarter bit
    localparam logic [19:0] PAGE        = 20'h43C00;
    localparam int          FRAME_CYC   = 38 * 4 * QDIV + 8;       // Start, 36 bits, stop, gap
    localparam int          TIMEOUT_CYC = 40 * FRAME_CYC;
    localparam logic [31:0] ADDR_A      = {PAGE, 12'h000};
    localparam logic [31:0] ADDR_B      = {PAGE, 12'h004};
    localparam logic [31:0] ADDR_GAP    = {PAGE, 12'h008};         // Unmapped offset
    localparam logic [31:0] ADDR_OFFPG  = {PAGE + 20'h1, 12'h000};  // Offset 0 of the next page

    logic        clk;
    logic        reset_i;
    logic        apb_psel_i;
    logic        apb_penable_i;
    logic        apb_pwrite_i;
    logic [31:0] apb_paddr_i;
    logic [31:0] apb_pwdata_i;
    logic [31:0] apb_prdata_o;
    logic        dor_a_i;
    logic        dor_b_i;
    logic        io_scl_o;
    logic        io_sda_o;

    logic [31:0] rng_state;
    logic [5:0]  reg_a;         // Register model
    logic [5:0]  reg_b;
    int          errors;
    int          checks;
    int          tests;
    int          cycles;
    int          fmt_errs;      // Errors found by the frame decoder

    // Frame decoder state
    logic        in_frame;
    logic [36:0] rx_bits;       // 36 data and ack bits plus the stop clock
    int          rx_cnt;
    int          frame_cnt;
    logic [15:0] rx_word;       // Word of the latest frame

    r24bb_panel_top #(
        .QUARTER_DIV (QDIV),
        .PAGE_BASE   (PAGE)
    ) dut_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .apb_psel_i    (apb_psel_i),
        .apb_penable_i (apb_penable_i),
        .apb_pwrite_i  (apb_pwrite_i),
        .apb_paddr_i   (apb_paddr_i),
        .apb_pwdata_i  (apb_pwdata_i),
        .apb_prdata_o  (apb_prdata_o),
        .dor_a_i       (dor_a_i),
        .dor_b_i       (dor_b_i),
        .io_scl_o      (io_scl_o),
        .io_sda_o      (io_sda_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT_CYC) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Test FAILED");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // Helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] next_rand();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Bit 0 flipped when the value would not change the register
    function automatic logic [5:0] force_change(input logic [5:0] v, input logic [5:0] cur);
        return (v == cur) ? (v ^ 6'h01) : v;
    endfunction

    // Expander pins from settings with LEDs and attenuator active low
    function automatic logic [15:0] model_word(input logic [5:0] a, input logic [5:0] b,
                                               input logic da, input logic db);
        logic [2:0] la;
        logic [2:0] lb;
        logic [7:0] p0;
        logic [7:0] p1;
        la = da ? 3'b100 : a[5:3];      // Overrange shows red only
        lb = db ? 3'b100 : b[5:3];
        p0 = {1'b0, a[2], ~a[1:0], 1'b0, b[2], ~b[1:0]};
        p1 = {1'b0, ~la[2], ~lb[2], 1'b0, ~lb[1:0], ~la[1:0]};
        return {p1, p0};
    endfunction

    function automatic logic [15:0] exp_word();
        return model_word(reg_a, reg_b, dor_a_i, dor_b_i);
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("FAILED %s expected 0x%0h actual 0x%0h", name, exp, act);
        end
    endtask

    task automatic end_test(input string name, input int err0);
        tests++;
        if (errors == err0)
            $display("test %-16s passed", name);
        else
            $display("test %-16s %0d errors", name, errors - err0);
    endtask

    // Starts and ends on a falling edge
    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data);
        apb_psel_i    = 1'b1;
        apb_penable_i = 1'b0;
        apb_pwrite_i  = 1'b1;
        apb_paddr_i   = addr;
        apb_pwdata_i  = data;
        @(negedge clk);
        apb_penable_i = 1'b1;           // Access cycle
        @(negedge clk);
        apb_psel_i    = 1'b0;
        apb_penable_i = 1'b0;
        apb_pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data);
        apb_psel_i    = 1'b1;
        apb_penable_i = 1'b0;
        apb_pwrite_i  = 1'b0;
        apb_paddr_i   = addr;
        @(negedge clk);
        apb_penable_i = 1'b1;
        @(posedge clk);
        data = apb_prdata_o;            // Valid in the access cycle with zero wait
        @(negedge clk);
        apb_psel_i    = 1'b0;
        apb_penable_i = 1'b0;
    endtask

    task automatic wait_frame(input int n0);
        while (frame_cnt == n0)
            @(negedge clk);
    endtask

    // Up to three frames until the newest word is on the pins
    task automatic settle(input string name);
        int tries;
        tries = 0;
        while (rx_word !== exp_word() && tries < 3) begin
            wait_frame(frame_cnt);
            tries++;
        end
        check_val(name, 32'(exp_word()), 32'(rx_word));
    endtask

    task automatic dor_step(input string name, input logic da, input logic db);
        int n0;
        n0 = frame_cnt;
        dor_a_i = da;
        dor_b_i = db;
        wait_frame(n0);
        check_val(name, 32'(exp_word()), 32'(rx_word));
    endtask

    //////////////////////////////////////////////////
    // I2C frame decoder
    //////////////////////////////////////////////////

    task automatic check_frame();
        int e0;
        e0 = errors;
        check_val("frame_bits", 32'd37, 32'(rx_cnt));
        check_val("frame_addr", 32'h40, 32'(rx_bits[36:29]));
        check_val("frame_cmd", 32'h02, 32'(rx_bits[27:20]));
        check_val("frame_acks", 32'hF,
                  32'({rx_bits[28], rx_bits[19], rx_bits[10], rx_bits[1]}));
        check_val("frame_stop_sda", 32'h0, 32'(rx_bits[0]));    // SDA low under stop clock
        rx_word  = {rx_bits[9:2], rx_bits[18:11]};              // Port 1 over port 0
        fmt_errs = fmt_errs + (errors - e0);
        frame_cnt++;
    endtask

    // Start condition when SDA falls with SCL high
    always @(negedge io_sda_o) begin
        if (!reset_i && io_scl_o === 1'b1) begin
            assert (!in_frame) else begin
                errors++;
                fmt_errs++;
                $display("Repeated start condition inside frame %0d", frame_cnt);
            end
            in_frame = 1'b1;
            rx_bits  = '0;
            rx_cnt   = 0;
        end
    end

    always @(posedge io_scl_o) begin
        if (!reset_i && in_frame) begin
            rx_bits = {rx_bits[35:0], io_sda_o};
            rx_cnt++;
        end
    end

    // Stop condition when SDA rises with SCL high
    always @(posedge io_sda_o) begin
        if (!reset_i && io_scl_o === 1'b1) begin
            assert (in_frame) else begin
                errors++;
                fmt_errs++;
                $display("Stop condition seen without a start condition");
            end
            if (in_frame)
                check_frame();
            in_frame = 1'b0;
        end
    end

    //////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0] r;
        logic [31:0] wdata;
        logic [31:0] rdata;
        int          n0;
        int          err0;

        reset_i       = 1'b1;
        apb_psel_i    = 1'b0;
        apb_penable_i = 1'b0;
        apb_pwrite_i  = 1'b0;
        apb_paddr_i   = '0;
        apb_pwdata_i  = '0;
        dor_a_i       = 1'b0;
        dor_b_i       = 1'b0;
        rng_state     = 32'd44;
        reg_a         = '0;
        reg_b         = '0;
        in_frame      = 1'b0;
        rx_bits       = '0;
        rx_cnt        = 0;
        rx_word       = '0;
        frame_cnt     = 0;
        errors        = 0;
        checks        = 0;
        tests         = 0;
        cycles        = 0;
        fmt_errs      = 0;

        repeat (10) @(negedge clk);
        reset_i = 1'b0;

        // Idle pins and then the first frame without any write
        err0 = errors;
        check_val("scl_after_reset", 32'd1, 32'(io_scl_o));
        check_val("sda_after_reset", 32'd1, 32'(io_sda_o));
        wait_frame(0);
        check_val("first_port0", 32'h33, 32'(rx_word[7:0]));
        check_val("first_port1", 32'h6F, 32'(rx_word[15:8]));
        check_val("first_model", 32'(exp_word()), 32'(rx_word));
        end_test("reset_frame", err0);

        // Read-back with random upper bits
        err0 = errors;
        r     = next_rand();
        wdata = {r[31:6], force_change(r[5:0], reg_a)};
        apb_write(ADDR_A, wdata);
        reg_a = wdata[5:0];
        r     = next_rand();
        wdata = {r[31:6], force_change(r[5:0], reg_b)};
        apb_write(ADDR_B, wdata);
        reg_b = wdata[5:0];
        apb_read(ADDR_A, rdata);
        check_val("read_a", {26'd0, reg_a}, rdata);
        apb_read(ADDR_B, rdata);
        check_val("read_b", {26'd0, reg_b}, rdata);
        apb_write(ADDR_GAP, 32'hFFFF_FFFF);
        apb_write(ADDR_OFFPG, 32'hFFFF_FFFF);
        apb_read(ADDR_GAP, rdata);
        check_val("read_unmapped", 32'h0, rdata);
        apb_read(ADDR_OFFPG, rdata);
        check_val("read_other_page", 32'h0, rdata);
        apb_read(ADDR_A, rdata);
        check_val("read_a_kept", {26'd0, reg_a}, rdata);
        apb_read(ADDR_B, rdata);
        check_val("read_b_kept", {26'd0, reg_b}, rdata);
        settle("regs_word");
        end_test("reg_readback", err0);

        // DUT is idle here so the next frame must carry the new word
        err0 = errors;
        for (int i = 0; i < 6; i++) begin
            r  = next_rand();
            n0 = frame_cnt;
            if (r[8]) begin
                reg_a = force_change(r[5:0], reg_a);
                apb_write(ADDR_A, {r[31:6], reg_a});
            end else begin
                reg_b = force_change(r[5:0], reg_b);
                apb_write(ADDR_B, {r[31:6], reg_b});
            end
            wait_frame(n0);
            check_val($sformatf("rand_write_%0d", i), 32'(exp_word()), 32'(rx_word));
        end
        end_test("write_to_frame", err0);

        // Green and blue lit on both channels first
        err0 = errors;
        reg_a = 6'b011_1_01;
        reg_b = 6'b011_0_10;
        apb_write(ADDR_A, {26'd0, reg_a});
        apb_write(ADDR_B, {26'd0, reg_b});
        settle("dor_setup");
        dor_step("dor_a_on", 1'b1, 1'b0);
        check_val("dor_a_leds", 32'b011, 32'({rx_word[14], rx_word[9:8]}));
        dor_step("dor_a_off", 1'b0, 1'b0);
        dor_step("dor_b_on", 1'b0, 1'b1);
        check_val("dor_b_leds", 32'b011, 32'({rx_word[13], rx_word[11:10]}));
        dor_step("dor_b_off", 1'b0, 1'b0);
        end_test("overrange", err0);

        // Same values again while the bus stays quiet
        err0 = errors;
        n0   = frame_cnt;
        apb_write(ADDR_A, {26'd0, reg_a});
        apb_write(ADDR_B, {26'd0, reg_b});
        repeat (3 * FRAME_CYC) @(negedge clk);
        check_val("same_value_frames", 32'(n0), 32'(frame_cnt));
        end_test("same_value", err0);

        tests++;
        assert (!in_frame) else begin
            errors++;
            fmt_errs++;
            $display("Frame on the expander pins never reached a stop condition");
        end
        $display("test %-16s %0d frames, %0d errors", "frame_format", frame_cnt, fmt_errs);

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

//--- list.f
verilog/panel_pkg.sv
verilog/i2c_timer_if.sv
verilog/channel_regs.sv
verilog/panel_io_map.sv
verilog/i2c_bit_timer.sv
verilog/i2c_frame_shifter.sv
verilog/i2c_frame_fsm.sv
verilog/r24bb_panel_top.sv
dv/tb_panel.sv

//--- verilog/channel_regs.sv
`timescale 1ns/10ps

module channel_regs #(
    parameter logic [19:0] PAGE_BASE = 20'h43C00    // Upper address bits of this page
) (
    input  logic                clk,
    input  logic                reset_i,

    // APB slave, zero wait
    input  logic                psel_i,
    input  logic                penable_i,
    input  logic                pwrite_i,
    input  panel_pkg::apb_addr_t paddr_i,
    input  panel_pkg::apb_data_t pwdata_i,
    output panel_pkg::apb_data_t prdata_o,

    // Channel A settings
    output panel_pkg::att_t     a_att_o,
    output logic                a_amp_en_o,
    output panel_pkg::led_t     a_led_o,

    // Channel B settings
    output panel_pkg::att_t     b_att_o,
    output logic                b_amp_en_o,
    output panel_pkg::led_t     b_led_o
);

    import panel_pkg::*;

    logic [5:0] a_ctrl;     // {led, amp_en, att}
    logic [5:0] b_ctrl;
    logic       page_hit;
    logic       a_hit;
    logic       b_hit;
    logic       wr_en;

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    assign page_hit = psel_i && (paddr_i[31:12] == PAGE_BASE);
    assign a_hit    = page_hit && (paddr_i[11:0] == CHA_CTRL_OFS);
    assign b_hit    = page_hit && (paddr_i[11:0] == CHB_CTRL_OFS);
    assign wr_en    = penable_i && pwrite_i;     // Access phase of a write

    // Write lands on the edge closing the access cycle
    always_ff @(posedge clk) begin
        if (reset_i) begin
            a_ctrl <= '0;
            b_ctrl <= '0;
        end else begin
            if (wr_en && a_hit)
                a_ctrl <= pwdata_i[5:0];
            if (wr_en && b_hit)
                b_ctrl <= pwdata_i[5:0];
        end
    end

    // Read mux, unmapped offsets and upper bits give zero
    always_comb begin
        prdata_o = '0;
        if (a_hit)
            prdata_o = apb_data_t'(a_ctrl);
        else if (b_hit)
            prdata_o = apb_data_t'(b_ctrl);
    end

    // Field split
    assign a_att_o    = a_ctrl[1:0];
    assign a_amp_en_o = a_ctrl[2];
    assign a_led_o    = a_ctrl[5:3];
    assign b_att_o    = b_ctrl[1:0];
    assign b_amp_en_o = b_ctrl[2];
    assign b_led_o    = b_ctrl[5:3];

endmodule

//--- verilog/i2c_bit_timer.sv
`timescale 1ns/10ps

module i2c_bit_timer #(
    parameter int QUARTER_DIV = 63     // Clocks per quarter bit
) (
    input  logic            clk,
    input  logic            reset_i,
    i2c_timer_if.timer_mp   tmr
);

    localparam int CNT_W = (QUARTER_DIV > 1) ? $clog2(QUARTER_DIV) : 1;

    logic [CNT_W-1:0] presc;
    logic [1:0]       quarter;
    logic             busy;
    logic             run;
    logic             quarter_end;
    logic             bit_done;

    // bit_start cycle counts as the first clock of quarter 0
    assign run         = busy || tmr.bit_start;
    assign quarter_end = (presc == CNT_W'(QUARTER_DIV - 1));

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy     <= 1'b0;
            presc    <= '0;
            quarter  <= '0;
            bit_done <= 1'b0;
        end else begin
            bit_done <= 1'b0;
            if (run) begin
                if (quarter_end) begin
                    presc    <= '0;
                    quarter  <= quarter + 2'd1;     // Wraps back to 0 at bit end
                    busy     <= (quarter != 2'd3);
                    bit_done <= (quarter == 2'd3);
                end else begin
                    presc <= presc + 1'b1;
                    busy  <= 1'b1;
                end
            end
        end
    end

    assign tmr.quarter      = quarter;
    assign tmr.quarter_tick = run && (presc == '0);    // Four per bit
    assign tmr.bit_done     = bit_done;                // Timer already idle here

endmodule

//--- verilog/i2c_frame_fsm.sv
`timescale 1ns/10ps

module i2c_frame_fsm (
    input  logic            clk,
    input  logic            reset_i,
    i2c_timer_if.fsm_mp     tmr,
    input  logic            pending_i,    // Shifter holds an unsent word
    input  logic            bit_i,        // Data bit from shifter
    output logic            load_o,
    output logic            shift_o,
    output logic            scl_o,
    output logic            sda_o
);

    import panel_pkg::*;

    frame_state_t state;
    frame_state_t state_nxt;
    logic [2:0]   bit_cnt;      // Bit within byte, wraps after 8
    logic [1:0]   byte_cnt;     // Byte within frame, wraps after 4
    logic         tick_q;       // Quarter tick, one cycle late
    logic [1:0]   qtr_q;        // Quarter seen at that tick
    logic         scl_nxt;

    //////////////////////////////////////////////////
    // Sequencing
    //////////////////////////////////////////////////

    always_comb begin
        state_nxt = state;
        unique case (state)
            IDLE:  if (pending_i) state_nxt = START;
            START: if (tmr.bit_done) state_nxt = BYTE;
            BYTE:  if (tmr.bit_done && bit_cnt == 3'd7) state_nxt = ACK;
            ACK:   if (tmr.bit_done) state_nxt = (byte_cnt == 2'd3) ? STOP : BYTE;
            STOP:  if (tmr.bit_done) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // Next bit starts right in the bit_done cycle, so bits sit back to back
    assign tmr.bit_start = (state_nxt != IDLE) && (state_nxt != state || tmr.bit_done);
    assign load_o        = (state == IDLE) && pending_i;
    // Advance after SDA has taken the bit
    assign shift_o       = (state == BYTE) && tmr.quarter_tick && (tmr.quarter == 2'd2);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state    <= IDLE;
            bit_cnt  <= '0;
            byte_cnt <= '0;
        end else begin
            state <= state_nxt;
            if (tmr.bit_done && state == BYTE)
                bit_cnt <= bit_cnt + 3'd1;
            if (tmr.bit_done && state == ACK)
                byte_cnt <= byte_cnt + 2'd1;
        end
    end

    //////////////////////////////////////////////////
    // Pins
    //////////////////////////////////////////////////

    // SCL per quarter, state_nxt covers the tick in the bit_start cycle
    always_comb begin
        unique case (state_nxt)
            START:   scl_nxt = 1'b1;                      // Held high, SDA falls under it
            STOP:    scl_nxt = (tmr.quarter != 2'd0);     // Up before SDA rises
            BYTE,
            ACK:     scl_nxt = tmr.quarter[1];            // Low q0 q1, high q2 q3
            default: scl_nxt = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            scl_o  <= 1'b1;
            sda_o  <= 1'b1;
            tick_q <= 1'b0;
        end else begin
            tick_q <= tmr.quarter_tick;
            if (tmr.quarter_tick)
                scl_o <= scl_nxt;
            // SDA trails SCL by one clock so it never moves on an SCL edge
            if (tick_q) begin
                unique case (state)
                    START: sda_o <= (qtr_q < 2'd2);       // Start condition in q2
                    BYTE:  if (qtr_q == 2'd0) sda_o <= bit_i;
                    ACK:   sda_o <= 1'b1;                 // Released for the ack
                    STOP:  sda_o <= (qtr_q >= 2'd2);      // Stop condition in q2
                    default: sda_o <= 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge clk)
        qtr_q <= tmr.quarter;

endmodule

//--- verilog/i2c_frame_shifter.sv
`timescale 1ns/10ps

module i2c_frame_shifter (
    input  logic                 clk,
    input  logic                 reset_i,
    input  panel_pkg::io_word_t  word_i,
    input  logic                 load_i,      // Capture new frame
    input  logic                 shift_i,     // Next data bit
    output logic                 pending_o,   // Word not yet sent
    output logic                 bit_o        // Current data bit
);

    import panel_pkg::*;

    io_word_t    last_word;     // Word of the latest frame
    logic [31:0] frame_sr;      // addr, cmd, port 0, port 1
    logic        pending;

    // Pending flag, set after reset so the first frame goes out
    always_ff @(posedge clk) begin
        if (reset_i)
            pending <= 1'b1;
        else if (load_i)
            pending <= 1'b0;
        else if (word_i != last_word)
            pending <= 1'b1;      // Changed mid-frame, newest word goes next
    end

    //////////////////////////////////////////////////
    // Frame bytes, MSB first
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (load_i) begin
            last_word <= word_i;
            frame_sr  <= {IOEXP_ADDR_BYTE, IOEXP_CMD_OUT0, word_i[7:0], word_i[15:8]};
        end else if (shift_i) begin
            frame_sr <= {frame_sr[30:0], 1'b0};
        end
    end

    assign pending_o = pending;
    assign bit_o     = frame_sr[31];

endmodule

//--- verilog/i2c_timer_if.sv
`timescale 1ns/10ps

// Bit timing handshake between frame FSM and quarter-bit timer
interface i2c_timer_if;

    logic       bit_start;      // FSM asks for one bit period
    logic [1:0] quarter;        // Current quarter of the bit
    logic       quarter_tick;   // First cycle of each quarter
    logic       bit_done;       // Bit period over, timer idle again

    modport timer_mp (
        input  bit_start,
        output quarter,
        output quarter_tick,
        output bit_done
    );

    modport fsm_mp (
        output bit_start,
        input  quarter,
        input  quarter_tick,
        input  bit_done
    );

endinterface

//--- verilog/panel_io_map.sv
`timescale 1ns/10ps

module panel_io_map (
    input  logic                 clk,
    input  logic                 reset_i,
    input  panel_pkg::att_t      a_att_i,
    input  logic                 a_amp_en_i,
    input  panel_pkg::led_t      a_led_i,
    input  panel_pkg::att_t      b_att_i,
    input  logic                 b_amp_en_i,
    input  panel_pkg::led_t      b_led_i,
    input  logic                 dor_a_i,     // Channel A overrange
    input  logic                 dor_b_i,     // Channel B overrange
    output panel_pkg::io_word_t  word_o
);

    import panel_pkg::*;

    localparam io_word_t WORD_RST = 16'h6F33;   // Pins for all-zero settings

    led_t     a_led;
    led_t     b_led;
    io_word_t word_nxt;

    // Overrange lights red only
    function automatic led_t force_red(led_t led, logic dor);
        return dor ? 3'b100 : led;
    endfunction

    assign a_led = force_red(a_led_i, dor_a_i);
    assign b_led = force_red(b_led_i, dor_b_i);

    // LEDs are common-anode so active low, attenuator pins too
    assign word_nxt = {
        1'b0, ~a_led[2], ~b_led[2], 1'b0,                     // Port 1 [7:4]
        ~b_led[1], ~b_led[0], ~a_led[1], ~a_led[0],           // Port 1 [3:0]
        1'b0, a_amp_en_i, ~a_att_i[1], ~a_att_i[0],           // Port 0 [7:4]
        1'b0, b_amp_en_i, ~b_att_i[1], ~b_att_i[0]            // Port 0 [3:0]
    };

    always_ff @(posedge clk) begin
        if (reset_i)
            word_o <= WORD_RST;
        else
            word_o <= word_nxt;
    end

endmodule

//--- verilog/panel_pkg.sv
package panel_pkg;

    //////////////////////////////////////////////////
    // Widths
    //////////////////////////////////////////////////

    typedef logic [31:0] apb_addr_t;   // APB address
    typedef logic [31:0] apb_data_t;   // APB data word
    typedef logic [1:0]  att_t;        // Attenuator step
    typedef logic [2:0]  led_t;        // Green, blue, red from bit 0
    typedef logic [15:0] io_word_t;    // Port 1 high byte, port 0 low byte
    typedef logic [7:0]  byte_t;       // One I2C frame byte

    //////////////////////////////////////////////////
    // Register page offsets
    //////////////////////////////////////////////////

    localparam logic [11:0] CHA_CTRL_OFS = 12'h000;   // Channel A control
    localparam logic [11:0] CHB_CTRL_OFS = 12'h004;   // Channel B control

    //////////////////////////////////////////////////
    // I/O expander
    //////////////////////////////////////////////////

    // Device 0x20, R/W bit low
    localparam byte_t IOEXP_ADDR_BYTE = 8'h40;
    localparam byte_t IOEXP_CMD_OUT0  = 8'h02;        // Output port 0, auto-increments to port 1

    // Frame sequencer states
    typedef enum logic [2:0] {
        IDLE,
        START,
        BYTE,
        ACK,
        STOP
    } frame_state_t;

endpackage

//--- verilog/r24bb_panel_top.sv
`timescale 1ns/10ps

module r24bb_panel_top #(
    parameter int          QUARTER_DIV = 63,          // Clocks per quarter bit
    parameter logic [19:0] PAGE_BASE   = 20'h43C00    // APB page of channel regs
) (
    input  logic                 clk,
    input  logic                 reset_i,

    // APB
    input  logic                 apb_psel_i,
    input  logic                 apb_penable_i,
    input  logic                 apb_pwrite_i,
    input  panel_pkg::apb_addr_t apb_paddr_i,
    input  panel_pkg::apb_data_t apb_pwdata_i,
    output panel_pkg::apb_data_t apb_prdata_o,

    // ADC overrange
    input  logic                 dor_a_i,
    input  logic                 dor_b_i,

    // Front panel expander
    output logic                 io_scl_o,
    output logic                 io_sda_o
);

    import panel_pkg::*;

    att_t     a_att;
    logic     a_amp_en;
    led_t     a_led;
    att_t     b_att;
    logic     b_amp_en;
    led_t     b_led;
    io_word_t io_word;
    logic     pending;
    logic     load;
    logic     shift;
    logic     frame_bit;

    i2c_timer_if tmr_if ();

    //////////////////////////////////////////////////
    // Registers and pin map
    //////////////////////////////////////////////////

    channel_regs #(
        .PAGE_BASE (PAGE_BASE)
    ) regs_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .psel_i     (apb_psel_i),
        .penable_i  (apb_penable_i),
        .pwrite_i   (apb_pwrite_i),
        .paddr_i    (apb_paddr_i),
        .pwdata_i   (apb_pwdata_i),
        .prdata_o   (apb_prdata_o),
        .a_att_o    (a_att),
        .a_amp_en_o (a_amp_en),
        .a_led_o    (a_led),
        .b_att_o    (b_att),
        .b_amp_en_o (b_amp_en),
        .b_led_o    (b_led)
    );

    panel_io_map map_inst (
        .clk        (clk),
        .reset_i    (reset_i),
        .a_att_i    (a_att),
        .a_amp_en_i (a_amp_en),
        .a_led_i    (a_led),
        .b_att_i    (b_att),
        .b_amp_en_i (b_amp_en),
        .b_led_i    (b_led),
        .dor_a_i    (dor_a_i),
        .dor_b_i    (dor_b_i),
        .word_o     (io_word)
    );

    //////////////////////////////////////////////////
    // I2C serializer
    //////////////////////////////////////////////////

    i2c_bit_timer #(
        .QUARTER_DIV (QUARTER_DIV)
    ) timer_inst (
        .clk     (clk),
        .reset_i (reset_i),
        .tmr     (tmr_if.timer_mp)
    );

    i2c_frame_shifter shifter_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .word_i    (io_word),
        .load_i    (load),
        .shift_i   (shift),
        .pending_o (pending),
        .bit_o     (frame_bit)
    );

    i2c_frame_fsm fsm_inst (
        .clk       (clk),
        .reset_i   (reset_i),
        .tmr       (tmr_if.fsm_mp),
        .pending_i (pending),
        .bit_i     (frame_bit),
        .load_o    (load),
        .shift_o   (shift),
        .scl_o     (io_scl_o),
        .sda_o     (io_sda_o)
    );

endmodule
